// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := cpu_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: design/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  opcode_t           op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] result,
    output logic              cmp
);
    logic [4:0] shamt;

    assign shamt = b[4:0];  // Low five bits only.

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SHL:  result = a << shamt;
            OP_SHR:  result = a >> shamt;  // Logical.
            default: result = '0;
        endcase
    end

    // Flag value for the two compares.
    assign cmp = (op == OP_CMPLT) ? ($signed(a) < $signed(b)) : (a == b);

endmodule

`default_nettype wire

// File: design/cpu_control.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_control
    import cpu_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [DATA_W-1:0]    instr,
    input  logic                 instr_valid,
    output logic                 instr_take,
    output logic                 redirect,
    output logic [ADDR_W-1:0]    redirect_pc,
    output logic [REG_IDX_W-1:0] ra_idx,
    output logic [REG_IDX_W-1:0] rb_idx,
    output logic [REG_IDX_W-1:0] fa_idx,
    output logic [REG_IDX_W-1:0] fb_idx,
    input  logic [DATA_W-1:0]    rd_data_a,
    input  logic [DATA_W-1:0]    rd_data_b,
    input  logic                 flag_a,
    input  logic                 flag_b,
    output logic                 wr_en,
    output logic [REG_IDX_W-1:0] wr_idx,
    output logic [DATA_W-1:0]    wr_data,
    output logic                 fwr_en,
    output logic [REG_IDX_W-1:0] fwr_idx,
    output logic                 fwr_data,
    output opcode_t              alu_op,
    output logic [DATA_W-1:0]    alu_a,
    output logic [DATA_W-1:0]    alu_b,
    input  logic [DATA_W-1:0]    alu_result,
    input  logic                 alu_cmp,
    output logic                 ls_start,
    output logic                 ls_we,
    output logic [ADDR_W-1:0]    ls_addr,
    output logic [DATA_W-1:0]    ls_wdata,
    input  logic                 ls_done,
    input  logic [DATA_W-1:0]    ls_rdata,
    output logic                 halted
);
    ctrl_state_t          state;
    logic [DATA_W-1:0]    ir;
    logic                 ir_valid;
    opcode_t              op;
    logic [REG_IDX_W-1:0] rd;
    logic [IMM_W-1:0]     imm;
    logic [DATA_W-1:0]    imm_sx;
    logic [DATA_W-1:0]    eff_addr;
    logic                 exec;
    logic                 is_alu;
    logic                 is_cmp;
    logic                 is_mem;
    logic                 is_simple;
    logic                 is_halt;
    logic [REG_IDX_W-1:0] chk_fidx;  // Last flag written.

    // ==============================
    // Decode
    // ==============================
    assign op     = opcode_t'(ir[OPC_HI:OPC_LO]);
    assign rd     = ir[RD_HI:RD_LO];
    assign imm    = ir[IMM_HI:IMM_LO];
    assign imm_sx = {{(DATA_W - IMM_W){imm[IMM_W-1]}}, imm};
    assign exec   = (state == S_EXEC) && ir_valid;

    assign is_alu    = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
    assign is_cmp    = op inside {OP_CMPEQ, OP_CMPLT};
    assign is_mem    = op inside {OP_LD, OP_ST};
    assign is_simple = is_alu || is_cmp || (op == OP_LDI);
    assign is_halt   = !(is_simple || is_mem || op == OP_BRF || op == OP_JMP);  // Undefined too.

    // Pipelined take only behind single-cycle work.
    assign instr_take = instr_valid && (state == S_EXEC) && (!ir_valid || is_simple);

    // ==============================
    // Datapath controls
    // ==============================
    assign ra_idx = ir[RA_HI:RA_LO];
    assign rb_idx = ir[RB_HI:RB_LO];
    assign fa_idx = rd;
    assign fb_idx = chk_fidx;

    assign alu_op = op;
    assign alu_a  = rd_data_a;
    assign alu_b  = rd_data_b;

    assign wr_idx  = rd;
    assign wr_en   = (exec && (is_alu || op == OP_LDI))
                   || (state == S_MEM_WAIT && ls_done && op == OP_LD);
    assign wr_data = (state == S_MEM_WAIT) ? ls_rdata :
                     (op == OP_LDI)        ? imm_sx   : alu_result;

    assign fwr_en   = exec && is_cmp;
    assign fwr_idx  = rd;
    assign fwr_data = alu_cmp;

    assign redirect    = exec && ((op == OP_JMP) || (op == OP_BRF && flag_a));
    assign redirect_pc = ADDR_W'(imm);

    assign eff_addr = rd_data_a + imm_sx;
    assign ls_start = exec && is_mem;
    assign ls_we    = (op == OP_ST);
    assign ls_addr  = eff_addr[ADDR_W-1:0];
    assign ls_wdata = rd_data_b;

    assign halted = (state == S_HALT);

    // ==============================
    // FSM
    // ==============================
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= S_EXEC;
            ir_valid <= 1'b0;
        end else begin
            case (state)
                S_EXEC: begin
                    ir_valid <= instr_take;
                    if (exec && is_mem) begin
                        state <= S_MEM_WAIT;
                    end else if (exec && is_halt) begin
                        state <= S_HALT;
                    end
                end
                S_MEM_WAIT: begin
                    if (ls_done) state <= S_EXEC;
                end
                default: begin
                    state    <= S_HALT;  // Stays until reset.
                    ir_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (instr_take) ir <= instr;
        if (fwr_en) chk_fidx <= fwr_idx;
    end

    // Compare result reads back from the flag file.
    a_flag_wb: assert property (@(posedge clock) disable iff (!rst_n)
        fwr_en |=> flag_b == $past(fwr_data));

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ==============================
    // Machine sizes
    // ==============================
    localparam int DATA_W    = 32;
    localparam int NREGS     = 8;
    localparam int REG_IDX_W = 3;
    localparam int IMM_W     = 16;

    // ==============================
    // Instruction fields
    // ==============================
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 27;
    localparam int RD_HI  = 26;
    localparam int RD_LO  = 24;
    localparam int RA_HI  = 23;
    localparam int RA_LO  = 21;
    localparam int RB_HI  = 20;
    localparam int RB_LO  = 18;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_SUB   = 5'd1,
        OP_AND   = 5'd2,
        OP_OR    = 5'd3,
        OP_XOR   = 5'd4,
        OP_SHL   = 5'd5,
        OP_SHR   = 5'd6,
        OP_LDI   = 5'd7,   // Sign-extended immediate.
        OP_LD    = 5'd8,
        OP_ST    = 5'd9,
        OP_CMPEQ = 5'd10,
        OP_CMPLT = 5'd11,  // Signed.
        OP_BRF   = 5'd12,
        OP_JMP   = 5'd13,
        OP_HALT  = 5'd14
    } opcode_t;

    typedef enum logic [1:0] {
        S_EXEC     = 2'd0,
        S_MEM_WAIT = 2'd1,
        S_HALT     = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top
    import cpu_pkg::*;
#(
    parameter int ADDR_W   = 16,
    parameter int RESET_PC = 0
) (
    input  logic              clock,
    input  logic              rst_n,
    output logic              mem_en,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    input  logic [DATA_W-1:0] mem_rdata,
    output logic              halted
);
    mem_bus_if #(.ADDR_W(ADDR_W)) fetch_bus ();
    mem_bus_if #(.ADDR_W(ADDR_W)) data_bus ();

    // Fetch to control.
    logic [DATA_W-1:0]    instr;
    logic                 instr_valid;
    logic                 instr_take;
    logic                 redirect;
    logic [ADDR_W-1:0]    redirect_pc;

    // Register file.
    logic [REG_IDX_W-1:0] ra_idx;
    logic [REG_IDX_W-1:0] rb_idx;
    logic [REG_IDX_W-1:0] fa_idx;
    logic [REG_IDX_W-1:0] fb_idx;
    logic [DATA_W-1:0]    rd_data_a;
    logic [DATA_W-1:0]    rd_data_b;
    logic                 flag_a;
    logic                 flag_b;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [DATA_W-1:0]    wr_data;
    logic                 fwr_en;
    logic [REG_IDX_W-1:0] fwr_idx;
    logic                 fwr_data;

    // ALU.
    opcode_t              alu_op;
    logic [DATA_W-1:0]    alu_a;
    logic [DATA_W-1:0]    alu_b;
    logic [DATA_W-1:0]    alu_result;
    logic                 alu_cmp;

    // Load/store.
    logic                 ls_start;
    logic                 ls_we;
    logic [ADDR_W-1:0]    ls_addr;
    logic [DATA_W-1:0]    ls_wdata;
    logic                 ls_done;
    logic [DATA_W-1:0]    ls_rdata;

    instr_fetch #(.ADDR_W(ADDR_W), .RESET_PC(RESET_PC)) u_fetch (.bus(fetch_bus), .*);

    load_store #(.ADDR_W(ADDR_W)) u_ls (.bus(data_bus), .*);

    mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (.fetch_bus(fetch_bus), .data_bus(data_bus), .*);

    cpu_control #(.ADDR_W(ADDR_W)) u_ctrl (.*);

    reg_file u_rf (.*);

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .cmp    (alu_cmp)
    );

endmodule

`default_nettype wire

// File: design/instr_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module instr_fetch
    import cpu_pkg::*;
#(
    parameter int ADDR_W   = 16,
    parameter int RESET_PC = 0
) (
    input  logic              clock,
    input  logic              rst_n,
    mem_bus_if.requester      bus,
    output logic [DATA_W-1:0] instr,
    output logic              instr_valid,
    input  logic              instr_take,
    input  logic              redirect,
    input  logic [ADDR_W-1:0] redirect_pc
);
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] buf_instr;
    logic              buf_valid;
    logic              in_flight;  // Read data on bus.rdata now.
    logic              discard;    // Wrong-path word coming back.
    logic              arriving;

    assign arriving    = in_flight && !discard;
    assign instr_valid = buf_valid || arriving;
    assign instr       = buf_valid ? buf_instr : bus.rdata;

    // Only one word is ever held or in flight.
    assign bus.req   = !instr_valid || instr_take;
    assign bus.we    = 1'b0;
    assign bus.addr  = pc;
    assign bus.wdata = '0;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc        <= ADDR_W'(RESET_PC);
            buf_valid <= 1'b0;
            in_flight <= 1'b0;
            discard   <= 1'b0;
        end else begin
            in_flight <= bus.gnt;
            discard   <= redirect && bus.gnt;
            if (redirect) begin
                pc        <= redirect_pc;
                buf_valid <= 1'b0;
            end else begin
                if (bus.gnt) pc <= pc + 1'b1;
                buf_valid <= instr_valid && !instr_take;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (arriving) buf_instr <= bus.rdata;
    end

    // Waiting requests hold still; a redirect here would change the address.
    a_req_stable: assert property (@(posedge clock) disable iff (!rst_n)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.addr));

endmodule

`default_nettype wire

// File: design/load_store.sv
`timescale 1ns/1ns
`default_nettype none

module load_store
    import cpu_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  logic              clock,
    input  logic              rst_n,
    mem_bus_if.requester      bus,
    input  logic              ls_start,
    input  logic              ls_we,
    input  logic [ADDR_W-1:0] ls_addr,
    input  logic [DATA_W-1:0] ls_wdata,
    output logic              ls_done,
    output logic [DATA_W-1:0] ls_rdata
);
    logic              req_q;
    logic              load_wait;  // Load granted, data next cycle.
    logic              we_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;

    assign bus.req   = req_q;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    // Stores finish on grant, loads one cycle later.
    assign ls_done  = (req_q && bus.gnt && we_q) || load_wait;
    assign ls_rdata = bus.rdata;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            load_wait <= 1'b0;
        end else begin
            load_wait <= req_q && bus.gnt && !we_q;
            if (ls_start) begin
                req_q <= 1'b1;
            end else if (bus.gnt) begin
                req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ls_start) begin
            we_q    <= ls_we;
            addr_q  <= ls_addr;
            wdata_q <= ls_wdata;
        end
    end

    a_no_overlap: assert property (@(posedge clock) disable iff (!rst_n)
        ls_start |-> !(req_q || load_wait));

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
    import cpu_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  logic              clock,
    input  logic              rst_n,
    mem_bus_if.arbiter        fetch_bus,
    mem_bus_if.arbiter        data_bus,
    output logic              mem_en,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    input  logic [DATA_W-1:0] mem_rdata
);
    logic ret_data;   // Read return goes to the data port.
    logic ret_fetch;

    // ==============================
    // Fixed priority, data first
    // ==============================
    assign data_bus.gnt  = data_bus.req;
    assign fetch_bus.gnt = fetch_bus.req && !data_bus.req;

    assign mem_en    = data_bus.req || fetch_bus.req;
    assign mem_we    = data_bus.req ? data_bus.we : fetch_bus.we;
    assign mem_addr  = data_bus.req ? data_bus.addr : fetch_bus.addr;
    assign mem_wdata = data_bus.req ? data_bus.wdata : fetch_bus.wdata;

    // ==============================
    // Read return routing
    // ==============================
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ret_data  <= 1'b0;
            ret_fetch <= 1'b0;
        end else begin
            ret_data  <= data_bus.gnt && !data_bus.we;
            ret_fetch <= fetch_bus.gnt && !fetch_bus.we;
        end
    end

    assign data_bus.rdata  = ret_data ? mem_rdata : '0;
    assign fetch_bus.rdata = ret_fetch ? mem_rdata : '0;

    // Data port is idle while its load data returns.
    a_ret_free: assert property (@(posedge clock) disable iff (!rst_n)
        ret_data |-> !data_bus.req);

endmodule

`default_nettype wire

// File: design/mem_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if
    import cpu_pkg::*;
#(
    parameter int ADDR_W = 16
) ();
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              gnt;    // One-cycle pulse when the access hits memory.
    logic [DATA_W-1:0] rdata;  // Valid the cycle after gnt.

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport arbiter (input req, we, addr, wdata, output gnt, rdata);
endinterface

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] ra_idx,
    input  logic [REG_IDX_W-1:0] rb_idx,
    output logic [DATA_W-1:0]    rd_data_a,
    output logic [DATA_W-1:0]    rd_data_b,
    input  logic [REG_IDX_W-1:0] fa_idx,
    input  logic [REG_IDX_W-1:0] fb_idx,
    output logic                 flag_a,
    output logic                 flag_b,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [DATA_W-1:0]    wr_data,
    input  logic                 fwr_en,
    input  logic [REG_IDX_W-1:0] fwr_idx,
    input  logic                 fwr_data
);
    logic [DATA_W-1:0] regs [NREGS];
    logic [NREGS-1:0]  flags;

    assign rd_data_a = regs[ra_idx];
    assign rd_data_b = regs[rb_idx];
    assign flag_a    = flags[fa_idx];
    assign flag_b    = flags[fb_idx];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (wr_en) regs[wr_idx] <= wr_data;
            if (fwr_en) flags[fwr_idx] <= fwr_data;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
design/cpu_pkg.sv
design/mem_bus_if.sv
design/reg_file.sv
design/alu.sv
design/instr_fetch.sv
design/load_store.sv
design/mem_arbiter.sv
design/cpu_control.sv
design/cpu_top.sv
tb/cpu_tb.sv

// File: tb/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
();
    localparam int          RESET_CYCLES = 8;
    localparam int          NTESTS       = 5;
    localparam int          T_ALU        = 0;
    localparam int          T_LDST       = 1;
    localparam int          T_BRANCH     = 2;
    localparam int          T_ORDER      = 3;
    localparam int          T_HALT       = 4;
    localparam logic [15:0] DBASE        = 16'h0100;  // Program lives below this.

    logic        clock = 1'b0;
    logic        rst_n;
    logic        mem_en;
    logic        mem_we;
    logic [15:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata = '0;
    logic        halted;

    logic [31:0] mem [0:65535];
    logic [31:0] rd_q = '0;
    integer      seed;
    int          pc_b;
    int          exec_count;
    bit          prog_ready;
    int          fail_tests;

    // Expected writes, in program order.
    int          exp_addr [0:63];
    logic [31:0] exp_data [0:63];
    int          exp_test [0:63];
    int          n_exp;
    int          last_wr [NTESTS];
    int          wr_cnt;
    int          report_q;
    bit          reported [NTESTS];
    int          test_err [NTESTS];
    bit          target_flag [0:255];
    logic [15:0] last_fetch;

    cpu_top #(.ADDR_W(16)) dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    always #2 clock = ~clock;

    // ==============================
    // Memory model
    // ==============================
    always @(posedge clock) begin
        if (mem_en) begin
            rd_q <= mem[mem_addr];
            if (mem_we) mem[mem_addr] <= mem_wdata;
        end
    end

    always @(posedge clock) begin
        #1;
        mem_rdata = rd_q;  // One cycle after the grant.
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic string test_name(int t);
        case (t)
            T_ALU:    return "alu_results";
            T_LDST:   return "load_store";
            T_BRANCH: return "compare_branch";
            T_ORDER:  return "arbitration_order";
            default:  return "halt";
        endcase
    endfunction

    function automatic logic [31:0] encode(opcode_t op, int rd, int ra, int rb, int imm);
        logic [31:0] w;
        w = '0;
        w[OPC_HI:OPC_LO] = op;
        w[RD_HI:RD_LO]   = rd[REG_IDX_W-1:0];
        w[RA_HI:RA_LO]   = ra[REG_IDX_W-1:0];
        w[RB_HI:RB_LO]   = rb[REG_IDX_W-1:0];
        w[IMM_HI:IMM_LO] = imm[IMM_W-1:0];
        return w;
    endfunction

    function automatic logic [31:0] sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] alu_model(opcode_t op, logic [31:0] a, logic [31:0] b);
        logic [31:0] scale;
        scale = 32'd1 << b[4:0];  // Shift as a power of two.
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SHL:  return a * scale;
            OP_SHR:  return a / scale;
            default: return 32'h0;
        endcase
    endfunction

    task automatic report_mismatch(input int t, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL %s: %s expected %h, actual %h", test_name(t), what, exp, act);
        test_err[t]++;
    endtask

    task automatic report_error(input int t, input string msg);
        $display("ERROR %s: %s", test_name(t), msg);
        test_err[t]++;
    endtask

    task automatic print_test_line(input int t);
        if (test_err[t] == 0) begin
            $display("test %s: passed", test_name(t));
        end else begin
            $display("test %s: %0d errors", test_name(t), test_err[t]);
        end
    endtask

    task automatic emit(input logic [31:0] w);
        mem[pc_b] = w;
        pc_b++;
    endtask

    task automatic expect_write(input int t, input int addr, input logic [31:0] data);
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        exp_test[n_exp] = t;
        last_wr[t]      = n_exp;
        n_exp++;
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {OP_HALT, 11'h0, 16'(i)};  // Stray fetches decode as halt.
        end
    endtask

    task automatic build_program();
        opcode_t     alu_ops [7];
        logic [15:0] ia;
        logic [15:0] ib;
        logic [15:0] val;
        int          n;
        int          loop_pc;
        int          skip_pc;
        alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
        pc_b    = 0;
        n_exp   = 0;
        ia      = 16'($random(seed));
        ib      = 16'($random(seed));
        emit(encode(OP_LDI, 1, 0, 0, int'(ia)));
        emit(encode(OP_LDI, 2, 0, 0, int'(ib)));
        for (int k = 0; k < 7; k++) begin
            emit(encode(alu_ops[k], 3, 1, 2, 0));
            emit(encode(OP_ST, 0, 0, 3, int'(DBASE) + k));
            expect_write(T_ALU, int'(DBASE) + k, alu_model(alu_ops[k], sext16(ia), sext16(ib)));
        end
        // Round trip through a second base register.
        val = 16'($random(seed));
        emit(encode(OP_LDI, 6, 0, 0, 'h120));
        emit(encode(OP_LDI, 4, 0, 0, int'(val)));
        emit(encode(OP_ST, 0, 6, 4, 2));
        emit(encode(OP_LD, 5, 0, 0, 'h122));
        emit(encode(OP_ST, 0, 6, 5, 3));
        expect_write(T_LDST, 'h122, sext16(val));
        expect_write(T_LDST, 'h123, sext16(val));
        // Counting loop, then a jump over a store.
        n = 3 + int'($unsigned($random(seed)) % 8);
        emit(encode(OP_LDI, 1, 0, 0, 0));
        emit(encode(OP_LDI, 2, 0, 0, 1));
        emit(encode(OP_LDI, 3, 0, 0, n));
        loop_pc = pc_b;
        target_flag[loop_pc] = 1'b1;
        emit(encode(OP_ADD, 1, 1, 2, 0));
        emit(encode(OP_CMPLT, 1, 1, 3, 0));
        emit(encode(OP_BRF, 1, 0, 0, loop_pc));
        emit(encode(OP_ST, 0, 0, 1, 'h130));
        expect_write(T_BRANCH, 'h130, 32'(n));
        skip_pc = pc_b + 2;
        target_flag[skip_pc] = 1'b1;
        emit(encode(OP_JMP, 0, 0, 0, skip_pc));
        emit(encode(OP_ST, 0, 0, 2, 'h1ff));  // Skipped.
        // Back-to-back stores.
        emit(encode(OP_ST, 0, 0, 1, 'h140));
        emit(encode(OP_ST, 0, 0, 2, 'h141));
        emit(encode(OP_ST, 0, 0, 4, 'h142));
        emit(encode(OP_ST, 0, 0, 6, 'h143));
        expect_write(T_ORDER, 'h140, 32'(n));
        expect_write(T_ORDER, 'h141, 32'd1);
        expect_write(T_ORDER, 'h142, sext16(val));
        expect_write(T_ORDER, 'h143, 32'h120);
        emit(encode(OP_HALT, 0, 0, 0, 0));
        emit(encode(OP_ST, 0, 0, 1, 'h150));  // Never runs.
        exec_count = pc_b + 3 * n;
    endtask

    // ==============================
    // Port tracking and checks
    // ==============================
    always @(posedge clock) begin
        if (!rst_n) begin
            wr_cnt     <= 0;
            report_q   <= -1;
            last_fetch <= 16'hffff;
        end else begin
            if (report_q >= 0) begin
                print_test_line(report_q);
                reported[report_q] = 1'b1;
            end
            report_q <= -1;
            if (mem_en && mem_we) begin
                wr_cnt <= wr_cnt + 1;
                if (wr_cnt < n_exp && exp_test[wr_cnt] <= T_BRANCH
                        && wr_cnt == last_wr[exp_test[wr_cnt]]) begin
                    report_q <= exp_test[wr_cnt];
                end
            end
            if (mem_en && !mem_we && mem_addr < DBASE) last_fetch <= mem_addr;
        end
    end

    a_wr_expected: assert property (@(posedge clock) disable iff (!rst_n)
        mem_en && mem_we |-> wr_cnt < n_exp)
        else report_error(T_ORDER, "store beyond the expected list");

    a_wr_addr: assert property (@(posedge clock) disable iff (!rst_n)
        mem_en && mem_we && wr_cnt < n_exp |-> mem_addr == 16'(exp_addr[wr_cnt]))
        else report_mismatch(exp_test[$sampled(wr_cnt)], "store address",
                             exp_addr[$sampled(wr_cnt)], 32'($sampled(mem_addr)));

    a_wr_data: assert property (@(posedge clock) disable iff (!rst_n)
        mem_en && mem_we && wr_cnt < n_exp |-> mem_wdata == exp_data[wr_cnt])
        else report_mismatch(exp_test[$sampled(wr_cnt)], "store data",
                             exp_data[$sampled(wr_cnt)], $sampled(mem_wdata));

    a_we_has_en: assert property (@(posedge clock) disable iff (!rst_n)
        mem_we |-> mem_en)
        else report_error(T_ORDER, "write strobe without memory enable");

    a_fetch_order: assert property (@(posedge clock) disable iff (!rst_n)
        mem_en && !mem_we && mem_addr < DBASE
        |-> mem_addr == last_fetch + 16'd1 || target_flag[mem_addr[7:0]])
        else report_mismatch(T_ORDER, "fetch address", 32'($sampled(last_fetch) + 16'd1),
                             32'($sampled(mem_addr)));

    a_all_writes: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(halted) |-> wr_cnt == n_exp)
        else report_mismatch(T_HALT, "stores before halt", n_exp, $sampled(wr_cnt));

    a_halt_stays: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted)
        else report_error(T_HALT, "halted dropped before reset");

    a_quiet_halt: assert property (@(posedge clock) disable iff (!rst_n)
        halted |-> !(mem_en && mem_we))
        else report_error(T_HALT, "memory write after halt");

    // ==============================
    // Run control
    // ==============================
    initial begin
        rst_n = 1'b0;
        seed  = 32'hacbb_c83b;
        fill_memory();
        build_program();
        prog_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 rst_n = 1'b1;
        while (!halted) @(posedge clock);
        repeat (20) @(posedge clock);  // Port must stay quiet.
        fail_tests = 0;
        for (int t = 0; t < NTESTS; t++) begin
            if (!reported[t]) print_test_line(t);
            if (test_err[t] != 0) fail_tests++;
        end
        $display("%0d tests run, %0d passed, %0d failed", NTESTS, NTESTS - fail_tests,
                 fail_tests);
        if (fail_tests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (prog_ready);
        repeat (RESET_CYCLES + exec_count * 10) @(posedge clock);
        $display("timeout: CPU did not halt within %0d cycles", exec_count * 10);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
